// File: design/rv_alu.sv
module rv_alu (
    input  rv_pkg::alu_op_e op,
    input  rv_pkg::word_t   a,
    input  rv_pkg::word_t   b,
    input  rv_pkg::branch_e branch_cond,
    input  rv_pkg::word_t   rs1_data,
    input  rv_pkg::word_t   rs2_data,
    output rv_pkg::word_t   result,
    output logic            taken
);
    import rv_pkg::*;

    logic [4:0] shamt;
    logic       lt_ab;
    logic       ltu_ab;
    logic       rs_eq;
    logic       rs_lt;
    logic       rs_ltu;

    assign shamt  = b[4:0];
    assign lt_ab  = $signed(a) < $signed(b);
    assign ltu_ab = a < b;

    always_comb begin
        case (op)
            alu_add:    result = a + b;
            alu_sub:    result = a - b;
            alu_sll:    result = a << shamt;
            alu_slt:    result = word_t'(lt_ab);
            alu_sltu:   result = word_t'(ltu_ab);
            alu_xor:    result = a ^ b;
            alu_srl:    result = a >> shamt;
            alu_sra:    result = word_t'($signed(a) >>> shamt);
            alu_or:     result = a | b;
            alu_and:    result = a & b;
            alu_pass_b: result = b;
            default:    result = a + b;
        endcase
    end

    // Branch compare works on the register operands, not on a and b
    assign rs_eq  = rs1_data == rs2_data;
    assign rs_lt  = $signed(rs1_data) < $signed(rs2_data);
    assign rs_ltu = rs1_data < rs2_data;

    always_comb begin
        case (branch_cond)
            br_eq:   taken = rs_eq;
            br_ne:   taken = !rs_eq;
            br_lt:   taken = rs_lt;
            br_ge:   taken = !rs_lt;
            br_ltu:  taken = rs_ltu;
            br_geu:  taken = !rs_ltu;
            default: taken = 1'b0;
        endcase
    end

endmodule

// File: design/rv_core.sv
module rv_core #(
    parameter rv_pkg::word_t RESET_PC = '0
) (
    input  logic          clk,
    input  logic          rst,
    input  rv_pkg::word_t inst,
    input  rv_pkg::word_t dmem_load_data,
    output rv_pkg::word_t pc,
    output rv_pkg::word_t dmem_addr,
    output rv_pkg::word_t dmem_store_data,
    output logic [3:0]    dmem_we,
    output logic          halt
);
    import rv_pkg::*;

    rv_inst_t  inst_u;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     rd_data;
    word_t     imm_i;
    word_t     imm_s;
    word_t     imm_b;
    word_t     imm_u;
    word_t     imm_j;
    alu_op_e   alu_op;
    logic      alu_src_imm;
    logic      alu_src_pc;
    logic      reg_write;
    wb_sel_e   wb_sel;
    logic      mem_read;
    logic      mem_write;
    mem_size_e mem_size;
    logic      mem_unsigned;
    logic      is_branch;
    logic      is_jal;
    logic      is_jalr;
    word_t     alu_a;
    word_t     alu_b;
    word_t     alu_result;
    logic      taken;
    word_t     pc_plus4;
    word_t     load_result;

    assign inst_u = inst;

    // PC as operand a always pairs with the U immediate (AUIPC, LUI)
    assign alu_a = alu_src_pc ? pc : rs1_data;
    assign alu_b = !alu_src_imm ? rs2_data : (alu_src_pc ? imm_u : imm_i);

    always_comb begin
        case (wb_sel)
            wb_load:     rd_data = load_result;
            wb_pc_plus4: rd_data = pc_plus4;
            default:     rd_data = alu_result;
        endcase
    end

    rv_regfile u_regfile (
        .clk      (clk),
        .rst      (rst),
        .we       (reg_write),
        .rd       (inst_u.r.rd),
        .rd_data  (rd_data),
        .rs1      (inst_u.r.rs1),
        .rs2      (inst_u.r.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    rv_imm_gen u_imm_gen (
        .inst  (inst_u),
        .imm_i (imm_i),
        .imm_s (imm_s),
        .imm_b (imm_b),
        .imm_u (imm_u),
        .imm_j (imm_j)
    );

    rv_decode u_decode (
        .inst         (inst_u),
        .alu_op       (alu_op),
        .alu_src_imm  (alu_src_imm),
        .alu_src_pc   (alu_src_pc),
        .reg_write    (reg_write),
        .wb_sel       (wb_sel),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_size     (mem_size),
        .mem_unsigned (mem_unsigned),
        .is_branch    (is_branch),
        .is_jal       (is_jal),
        .is_jalr      (is_jalr),
        .halt         (halt)
    );

    rv_alu u_alu (
        .op          (alu_op),
        .a           (alu_a),
        .b           (alu_b),
        .branch_cond (branch_e'(inst_u.b.funct3)),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .result      (alu_result),
        .taken       (taken)
    );

    rv_pc_unit #(
        .RESET_PC (RESET_PC)
    ) u_pc_unit (
        .clk       (clk),
        .rst       (rst),
        .halt      (halt),
        .is_branch (is_branch),
        .taken     (taken),
        .is_jal    (is_jal),
        .is_jalr   (is_jalr),
        .rs1_data  (rs1_data),
        .imm_i     (imm_i),
        .imm_b     (imm_b),
        .imm_j     (imm_j),
        .pc        (pc),
        .pc_plus4  (pc_plus4)
    );

    rv_lsu u_lsu (
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .mem_size        (mem_size),
        .mem_unsigned    (mem_unsigned),
        .rs1_data        (rs1_data),
        .rs2_data        (rs2_data),
        .imm_i           (imm_i),
        .imm_s           (imm_s),
        .dmem_load_data  (dmem_load_data),
        .dmem_addr       (dmem_addr),
        .dmem_store_data (dmem_store_data),
        .dmem_we         (dmem_we)
        ,.load_result    (load_result)
    );

    // Byte, aligned half or full word lanes only
    a_store_lanes: assert property (
        @(posedge clk) disable iff (rst)
        dmem_we inside {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000,
                        4'b0011, 4'b1100, 4'b1111}
    );

    // ECALL freezes the PC, so the same word keeps halt up
    a_halt_holds: assert property (
        @(posedge clk) disable iff (rst)
        halt |=> halt && $stable(pc)
    );

endmodule

// File: design/rv_decode.sv
module rv_decode (
    input  rv_pkg::rv_inst_t  inst,
    output rv_pkg::alu_op_e   alu_op,
    output logic              alu_src_imm,
    output logic              alu_src_pc,
    output logic              reg_write,
    output rv_pkg::wb_sel_e   wb_sel,
    output logic              mem_read,
    output logic              mem_write,
    output rv_pkg::mem_size_e mem_size,
    output logic              mem_unsigned,
    output logic              is_branch,
    output logic              is_jal,
    output logic              is_jalr,
    output logic              halt
);
    import rv_pkg::*;

    logic f7_zero;
    logic f7_alt;

    function automatic alu_op_e alu_from_funct3(logic [2:0] funct3, logic alt);
        case (funct3)
            3'b000:  return alt ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    assign f7_zero = inst.r.funct7 == 7'b0000000;
    assign f7_alt  = inst.r.funct7 == 7'b0100000;

    always_comb begin
        alu_op       = alu_add;
        alu_src_imm  = 1'b0;
        alu_src_pc   = 1'b0;
        reg_write    = 1'b0;
        wb_sel       = wb_alu;
        mem_read     = 1'b0;
        mem_write    = 1'b0;
        mem_size     = mem_word;
        mem_unsigned = inst.i.funct3[2];
        is_branch    = 1'b0;
        is_jal       = 1'b0;
        is_jalr      = 1'b0;
        halt         = 1'b0;

        case (inst.i.funct3[1:0])
            2'b00:   mem_size = mem_byte;
            2'b01:   mem_size = mem_half;
            default: mem_size = mem_word;
        endcase

        case (inst.r.opcode)
            op_lui: begin
                // pass_b ignores the PC operand, only the U immediate matters
                alu_op      = alu_pass_b;
                alu_src_imm = 1'b1;
                alu_src_pc  = 1'b1;
                reg_write   = 1'b1;
            end
            op_auipc: begin
                alu_src_imm = 1'b1;
                alu_src_pc  = 1'b1;
                reg_write   = 1'b1;
            end
            op_jal: begin
                is_jal    = 1'b1;
                reg_write = 1'b1;
                wb_sel    = wb_pc_plus4;
            end
            op_jalr: begin
                is_jalr   = 1'b1;
                reg_write = 1'b1;
                wb_sel    = wb_pc_plus4;
            end
            op_branch: begin
                is_branch = 1'b1;
            end
            op_load: begin
                // Only LB, LH, LW, LBU, LHU
                mem_read  = inst.i.funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
                reg_write = mem_read;
                wb_sel    = wb_load;
            end
            op_store: begin
                mem_write = inst.s.funct3 inside {3'b000, 3'b001, 3'b010};
            end
            op_reg_imm: begin
                alu_src_imm = 1'b1;
                alu_op      = alu_from_funct3(inst.r.funct3, f7_alt && inst.r.funct3 == 3'b101);
                case (inst.r.funct3)
                    3'b001:  reg_write = f7_zero;
                    3'b101:  reg_write = f7_zero || f7_alt;
                    default: reg_write = 1'b1;
                endcase
            end
            op_reg_reg: begin
                alu_op    = alu_from_funct3(inst.r.funct3, f7_alt);
                reg_write = f7_zero ||
                            (f7_alt && (inst.r.funct3 == 3'b000 || inst.r.funct3 == 3'b101));
            end
            op_system: begin
                // ECALL has every bit above the opcode clear
                halt = inst.u.imm == '0 && inst.u.rd == '0;
            end
            default: begin
                // FENCE and unknown opcodes retire as no-ops
            end
        endcase
    end

endmodule

// File: design/rv_imm_gen.sv
module rv_imm_gen (
    input  rv_pkg::rv_inst_t inst,
    output rv_pkg::word_t    imm_i,
    output rv_pkg::word_t    imm_s,
    output rv_pkg::word_t    imm_b,
    output rv_pkg::word_t    imm_u,
    output rv_pkg::word_t    imm_j
);
    import rv_pkg::*;

    assign imm_i = {{(XLEN-12){inst.i.imm[11]}}, inst.i.imm};

    assign imm_s = {{(XLEN-12){inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};

    // Branch offsets are in halfwords, bit 0 implied
    assign imm_b = {
        {(XLEN-12){inst.b.imm_12}},
        inst.b.imm_11,
        inst.b.imm_10_5,
        inst.b.imm_4_1,
        1'b0
    };

    assign imm_u = {inst.u.imm, 12'b0};

    assign imm_j = {
        {(XLEN-20){inst.j.imm_20}},
        inst.j.imm_19_12,
        inst.j.imm_11,
        inst.j.imm_10_1,
        1'b0
    };

endmodule

// File: design/rv_lsu.sv
module rv_lsu (
    input  logic              mem_read,
    input  logic              mem_write,
    input  rv_pkg::mem_size_e mem_size,
    input  logic              mem_unsigned,
    input  rv_pkg::word_t     rs1_data,
    input  rv_pkg::word_t     rs2_data,
    input  rv_pkg::word_t     imm_i,
    input  rv_pkg::word_t     imm_s,
    input  rv_pkg::word_t     dmem_load_data,
    output rv_pkg::word_t     dmem_addr,
    output rv_pkg::word_t     dmem_store_data,
    output logic [3:0]        dmem_we,
    output rv_pkg::word_t     load_result
);
    import rv_pkg::*;

    logic [1:0] offset;
    word_t      load_shifted;
    logic [7:0] load_byte;
    logic [15:0] load_half;

    assign dmem_addr = rs1_data + (mem_write ? imm_s : imm_i);
    assign offset    = dmem_addr[1:0];

    // Store data lines up with the addressed byte lane
    assign dmem_store_data = rs2_data << {offset, 3'b000};

    always_comb begin
        dmem_we = 4'b0000;
        if (mem_write) begin
            case (mem_size)
                mem_byte: dmem_we = 4'b0001 << offset;
                mem_half: dmem_we = offset[0] ? 4'b0000 : 4'b0011 << offset;
                default:  dmem_we = 4'b1111;
            endcase
        end
    end

    assign load_shifted = dmem_load_data >> {offset, 3'b000};
    assign load_byte    = load_shifted[7:0];
    assign load_half    = load_shifted[15:0];

    always_comb begin
        load_result = '0;
        if (mem_read) begin
            case (mem_size)
                mem_byte: begin
                    load_result = {{(XLEN-8){load_byte[7] && !mem_unsigned}}, load_byte};
                end
                mem_half: begin
                    // Misaligned half reads zero
                    if (!offset[0]) begin
                        load_result = {{(XLEN-16){load_half[15] && !mem_unsigned}}, load_half};
                    end
                end
                default: load_result = dmem_load_data;
            endcase
        end
    end

endmodule

// File: design/rv_pc_unit.sv
module rv_pc_unit #(
    parameter rv_pkg::word_t RESET_PC = '0
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          halt,
    input  logic          is_branch,
    input  logic          taken,
    input  logic          is_jal,
    input  logic          is_jalr,
    input  rv_pkg::word_t rs1_data,
    input  rv_pkg::word_t imm_i,
    input  rv_pkg::word_t imm_b,
    input  rv_pkg::word_t imm_j,
    output rv_pkg::word_t pc,
    output rv_pkg::word_t pc_plus4
);
    import rv_pkg::*;

    word_t pc_next;
    word_t jalr_target;

    assign pc_plus4    = pc + word_t'(4);
    assign jalr_target = rs1_data + imm_i;

    always_comb begin
        if (halt) begin
            pc_next = pc;
        end else if (is_jal) begin
            pc_next = pc + imm_j;
        end else if (is_jalr) begin
            pc_next = {jalr_target[XLEN-1:1], 1'b0};
        end else if (is_branch && taken) begin
            pc_next = pc + imm_b;
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    // Jump and branch targets must stay on word boundaries
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (rst) pc[1:0] == 2'b00
    );

endmodule

// File: design/rv_pkg.sv
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0] word_t;

    // Base opcodes, low two bits always 11
    typedef enum logic [6:0] {
        op_load     = 7'b0000011,
        op_misc_mem = 7'b0001111,
        op_reg_imm  = 7'b0010011,
        op_auipc    = 7'b0010111,
        op_store    = 7'b0100011,
        op_reg_reg  = 7'b0110011,
        op_lui      = 7'b0110111,
        op_branch   = 7'b1100011,
        op_jalr     = 7'b1100111,
        op_jal      = 7'b1101111,
        op_system   = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_op_e;

    // Same encoding as the branch funct3
    typedef enum logic [2:0] {
        br_eq  = 3'b000,
        br_ne  = 3'b001,
        br_lt  = 3'b100,
        br_ge  = 3'b101,
        br_ltu = 3'b110,
        br_geu = 3'b111
    } branch_e;

    typedef enum logic [1:0] {
        mem_byte = 2'b00,
        mem_half = 2'b01,
        mem_word = 2'b10
    } mem_size_e;

    typedef enum logic [1:0] {
        wb_alu,
        wb_load,
        wb_pc_plus4
    } wb_sel_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_e    opcode;
    } s_type_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_e    opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        opcode_e     opcode;
    } u_type_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        opcode_e    opcode;
    } j_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        b_type_t b;
        u_type_t u;
        j_type_t j;
    } rv_inst_t;

endpackage

// File: design/rv_regfile.sv
module rv_regfile (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          we,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rd,
    input  rv_pkg::word_t                 rd_data,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs1,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs2,
    output rv_pkg::word_t                 rs1_data,
    output rv_pkg::word_t                 rs2_data
);
    import rv_pkg::*;

    localparam int NUM_REGS = 2 ** REG_ADDR_W;

    word_t regs [NUM_REGS];

    // x0 always reads zero
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= rd_data;
        end
    end

    // Writing x0 leaves the read value untouched
    a_x0_write_ignored: assert property (
        @(posedge clk)
        (we && rd == '0 && !rst) ##1 $stable(rs1) |-> $stable(rs1_data)
    );

endmodule

// File: run.sh
#!/bin/sh
# Build and run the rv_core testbench with Verilator, from the project root
rm -f sim.log
verilator --binary --timing --assert --top-module rv_core_tb -f rv_core.f -o rv_core_sim \
    && ./obj_dir/rv_core_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^RESULT: PASS$" sim.log && echo "Simulation passed" && exit 0 \
    || { echo "Simulation failed"; exit 1; }

// File: rv_core.f
design/rv_pkg.sv
design/rv_regfile.sv
design/rv_imm_gen.sv
design/rv_decode.sv
design/rv_alu.sv
design/rv_pc_unit.sv
design/rv_lsu.sv
design/rv_core.sv
test/rv_core_tb.sv

// File: test/rv_core_tb.sv
module rv_core_tb;
    timeunit 1ns;
    timeprecision 1ns;

    localparam int    MEM_WORDS    = 1024;
    localparam int    RESET_CYCLES = 16;
    localparam int    HALF_PERIOD  = 20;
    localparam int    HALT_HOLD    = 4;
    localparam string TESTS_FILE   = "test/rv_core_tests.txt";

    logic        clk;
    logic        rst;
    logic [31:0] inst;
    logic [31:0] dmem_load_data;
    logic [31:0] pc;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_store_data;
    logic [3:0]  dmem_we;
    logic        halt;

    logic [31:0] mem [MEM_WORDS];

    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [3:0]  exp_we [$];
    int          exp_halt;
    bit          loaded;
    int          store_idx;
    int          cycle;
    int          errors;
    int          checks;

    rv_core #(
        .RESET_PC (32'h0000_0000)
    ) rv_core_inst (
        .clk             (clk),
        .rst             (rst),
        .inst            (inst),
        .dmem_load_data  (dmem_load_data),
        .pc              (pc),
        .dmem_addr       (dmem_addr),
        .dmem_store_data (dmem_store_data),
        .dmem_we         (dmem_we),
        .halt            (halt)
    );

    always #HALF_PERIOD clk = ~clk;

    // One memory for code and data, word addressed
    assign inst           = mem[pc[11:2]];
    assign dmem_load_data = mem[dmem_addr[11:2]];

    always @(posedge clk) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (dmem_we[lane]) begin
                mem[dmem_addr[11:2]][lane*8 +: 8] <= dmem_store_data[lane*8 +: 8];
            end
        end
        if (!rst && dmem_we != 4'b0000) begin
            check_store();
        end
    end

    task automatic check_store();
        if (store_idx >= exp_addr.size()) begin
            $display("Unexpected store at time %0t to %h after the expected trace ended",
                     $time, dmem_addr);
            errors++;
        end else begin
            checks++;
            if (dmem_addr !== exp_addr[store_idx]) begin
                $display("FAILED at time %0t: dmem_addr expected %h, got %h",
                         $time, exp_addr[store_idx], dmem_addr);
                errors++;
            end
            if (dmem_store_data !== exp_data[store_idx]) begin
                $display("FAILED at time %0t: dmem_store_data expected %h, got %h",
                         $time, exp_data[store_idx], dmem_store_data);
                errors++;
            end
            if (dmem_we !== exp_we[store_idx]) begin
                $display("FAILED at time %0t: dmem_we expected %b, got %b",
                         $time, exp_we[store_idx], dmem_we);
                errors++;
            end
            store_idx++;
        end
    endtask

    task automatic load_tests();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f0;
        logic [31:0] f1;
        logic [31:0] f2;
        // Unused words decode as a custom opcode and retire as no-ops
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = {12'ha5a, i[9:0], 10'h00b};
        end
        fd = $fopen(TESTS_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the tests file %s", TESTS_FILE);
            errors++;
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 0) begin
                    case (line[0])
                        "P": begin
                            n = $sscanf(line.substr(1, line.len() - 1), " %h %h", f0, f1);
                            mem[f0[11:2]] = f1;
                        end
                        "S": begin
                            n = $sscanf(line.substr(1, line.len() - 1), " %h %h %h",
                                        f0, f1, f2);
                            exp_addr.push_back(f0);
                            exp_data.push_back(f1);
                            exp_we.push_back(f2[3:0]);
                        end
                        "H": begin
                            n = $sscanf(line.substr(1, line.len() - 1), " %h", f0);
                            exp_halt = int'(f0);
                        end
                        default: begin
                        end
                    endcase
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic apply_reset();
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(negedge clk);
            checks++;
            if (pc !== 32'h0) begin
                $display("FAILED at time %0t: pc expected %h, got %h", $time, 32'h0, pc);
                errors++;
            end
            if (dmem_we !== 4'b0000) begin
                $display("FAILED at time %0t: dmem_we expected %b, got %b",
                         $time, 4'b0000, dmem_we);
                errors++;
            end
            if (halt !== 1'b0) begin
                $display("FAILED at time %0t: halt expected %b, got %b", $time, 1'b0, halt);
                errors++;
            end
        end
        rst = 1'b0;
    endtask

    task automatic run_to_halt();
        // Instruction number k is presented in the k-th cycle after release
        cycle = 0;
        while (halt !== 1'b1) begin
            @(negedge clk);
            cycle++;
        end
        checks++;
        if (cycle != exp_halt) begin
            $display("FAILED at time %0t: halt cycle expected %0d, got %0d",
                     $time, exp_halt, cycle);
            errors++;
        end
        for (int i = 0; i < HALT_HOLD; i++) begin
            @(negedge clk);
            checks++;
            if (halt !== 1'b1) begin
                $display("FAILED at time %0t: halt expected %b, got %b", $time, 1'b1, halt);
                errors++;
            end
        end
        @(negedge clk);
        checks++;
        if (store_idx != exp_addr.size()) begin
            $display("Only %0d of %0d expected stores were seen before halt",
                     store_idx, exp_addr.size());
            errors++;
        end
    endtask

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        exp_halt  = 0;
        loaded    = 1'b0;
        store_idx = 0;
        cycle     = 0;
        errors    = 0;
        checks    = 0;
        load_tests();
        loaded = 1'b1;
        if (exp_halt <= 0 || exp_addr.size() == 0) begin
            $display("The tests file gave no store trace or no halt count");
            errors++;
        end else begin
            apply_reset();
            run_to_halt();
        end
        finish_run();
    end

    // Limit scales with the program length
    initial begin
        wait (loaded);
        #((exp_halt + RESET_CYCLES + 20) * 2 * HALF_PERIOD);
        $display("Timeout: halt never came within %0d cycles after reset",
                 exp_halt + 20);
        errors++;
        finish_run();
    end

endmodule

// File: test/rv_core_tests.txt
# P <byte address> <instruction word>
# S <store address> <store data> <byte enable>, H <instructions retired before ECALL>; all hex
P 000 40000513  # addi x10, x0, 0x400
P 004 ffb00093  # addi x1, x0, -5
P 008 00300113  # addi x2, x0, 3
P 00c 402081b3  # sub x3, x1, x2
P 010 00352023  # sw x3, 0(x10)
P 014 00409213  # slli x4, x1, 4
P 018 00452023  # sw x4, 0(x10)
P 01c 4010d293  # srai x5, x1, 1
P 020 00552023  # sw x5, 0(x10)
P 024 0020d333  # srl x6, x1, x2
P 028 00652023  # sw x6, 0(x10)
P 02c 0020a3b3  # slt x7, x1, x2
P 030 00752023  # sw x7, 0(x10)
P 034 0020b433  # sltu x8, x1, x2
P 038 00852023  # sw x8, 0(x10)
P 03c 0020c4b3  # xor x9, x1, x2
P 040 00952023  # sw x9, 0(x10)
P 044 0020e5b3  # or x11, x1, x2
P 048 00b52023  # sw x11, 0(x10)
P 04c 0020f633  # and x12, x1, x2
P 050 00c52023  # sw x12, 0(x10)
P 054 123456b7  # lui x13, 0x12345
P 058 67868693  # addi x13, x13, 0x678
P 05c 00d52023  # sw x13, 0(x10)
P 060 00001717  # auipc x14, 0x1
P 064 00e52023  # sw x14, 0(x10)
# Load source word 0xc2347e81 at 0x404
P 068 c23487b7  # lui x15, 0xc2348
P 06c e8178793  # addi x15, x15, -0x17f
P 070 00f52223  # sw x15, 4(x10)
P 074 00450803  # lb x16, 4(x10)
P 078 01052023  # sw x16, 0(x10)
P 07c 00550803  # lb x16, 5(x10)
P 080 01052023  # sw x16, 0(x10)
P 084 00650803  # lb x16, 6(x10)
P 088 01052023  # sw x16, 0(x10)
P 08c 00750803  # lb x16, 7(x10)
P 090 01052023  # sw x16, 0(x10)
P 094 00454803  # lbu x16, 4(x10)
P 098 01052023  # sw x16, 0(x10)
P 09c 00554803  # lbu x16, 5(x10)
P 0a0 01052023  # sw x16, 0(x10)
P 0a4 00654803  # lbu x16, 6(x10)
P 0a8 01052023  # sw x16, 0(x10)
P 0ac 00754803  # lbu x16, 7(x10)
P 0b0 01052023  # sw x16, 0(x10)
P 0b4 00451803  # lh x16, 4(x10)
P 0b8 01052023  # sw x16, 0(x10)
P 0bc 00651803  # lh x16, 6(x10)
P 0c0 01052023  # sw x16, 0(x10)
P 0c4 00455803  # lhu x16, 4(x10)
P 0c8 01052023  # sw x16, 0(x10)
P 0cc 00655803  # lhu x16, 6(x10)
P 0d0 01052023  # sw x16, 0(x10)
P 0d4 00452803  # lw x16, 4(x10)
P 0d8 01052023  # sw x16, 0(x10)
P 0dc 00d50423  # sb x13, 8(x10)
P 0e0 00d504a3  # sb x13, 9(x10)
P 0e4 00d50523  # sb x13, 10(x10)
P 0e8 00d505a3  # sb x13, 11(x10)
P 0ec 00d51423  # sh x13, 8(x10)
P 0f0 00d51523  # sh x13, 10(x10)
P 0f4 00852803  # lw x16, 8(x10)
P 0f8 01052023  # sw x16, 0(x10)
# Branch markers, x17 on fall-through and x18 at the target
P 0fc 00f00893  # addi x17, x0, 0x0f
P 100 07a00913  # addi x18, x0, 0x7a
P 104 00210463  # beq x2, x2, +8
P 108 01152023  # sw x17, 0(x10)
P 10c 01252023  # sw x18, 0(x10)
P 110 00208463  # beq x1, x2, +8
P 114 01152023  # sw x17, 0(x10)
P 118 01252023  # sw x18, 0(x10)
P 11c 00209463  # bne x1, x2, +8
P 120 01152023  # sw x17, 0(x10)
P 124 01252023  # sw x18, 0(x10)
P 128 00211463  # bne x2, x2, +8
P 12c 01152023  # sw x17, 0(x10)
P 130 01252023  # sw x18, 0(x10)
P 134 0020c463  # blt x1, x2, +8
P 138 01152023  # sw x17, 0(x10)
P 13c 01252023  # sw x18, 0(x10)
P 140 00114463  # blt x2, x1, +8
P 144 01152023  # sw x17, 0(x10)
P 148 01252023  # sw x18, 0(x10)
P 14c 00115463  # bge x2, x1, +8
P 150 01152023  # sw x17, 0(x10)
P 154 01252023  # sw x18, 0(x10)
P 158 0020d463  # bge x1, x2, +8
P 15c 01152023  # sw x17, 0(x10)
P 160 01252023  # sw x18, 0(x10)
P 164 00116463  # bltu x2, x1, +8
P 168 01152023  # sw x17, 0(x10)
P 16c 01252023  # sw x18, 0(x10)
P 170 0020e463  # bltu x1, x2, +8
P 174 01152023  # sw x17, 0(x10)
P 178 01252023  # sw x18, 0(x10)
P 17c 0020f463  # bgeu x1, x2, +8
P 180 01152023  # sw x17, 0(x10)
P 184 01252023  # sw x18, 0(x10)
P 188 00117463  # bgeu x2, x1, +8
P 18c 01152023  # sw x17, 0(x10)
P 190 01252023  # sw x18, 0(x10)
P 194 008009ef  # jal x19, +8
P 198 01152023  # sw x17, 0(x10)
P 19c 01352023  # sw x19, 0(x10)
P 1a0 1a000a13  # addi x20, x0, 0x1a0
P 1a4 00da0ae7  # jalr x21, 13(x20)
P 1a8 01152023  # sw x17, 0(x10)
P 1ac 01552023  # sw x21, 0(x10)
P 1b0 00000073  # ecall
S 400 fffffff8 f
S 400 ffffffb0 f
S 400 fffffffd f
S 400 1fffffff f
S 400 00000001 f
S 400 00000000 f
S 400 fffffff8 f
S 400 fffffffb f
S 400 00000003 f
S 400 12345678 f
S 400 00001060 f
S 404 c2347e81 f
S 400 ffffff81 f
S 400 0000007e f
S 400 00000034 f
S 400 ffffffc2 f
S 400 00000081 f
S 400 0000007e f
S 400 00000034 f
S 400 000000c2 f
S 400 00007e81 f
S 400 ffffc234 f
S 400 00007e81 f
S 400 0000c234 f
S 400 c2347e81 f
S 408 12345678 1
S 409 34567800 2
S 40a 56780000 4
S 40b 78000000 8
S 408 12345678 3
S 40a 56780000 c
S 400 56785678 f
S 400 0000007a f
S 400 0000000f f
S 400 0000007a f
S 400 0000007a f
S 400 0000000f f
S 400 0000007a f
S 400 0000007a f
S 400 0000000f f
S 400 0000007a f
S 400 0000007a f
S 400 0000000f f
S 400 0000007a f
S 400 0000007a f
S 400 0000000f f
S 400 0000007a f
S 400 0000007a f
S 400 0000000f f
S 400 0000007a f
S 400 00000198 f
S 400 000001a8 f
H 64
